// File: common/ram2ePkg.sv
`default_nettype none

package ram2ePkg;

    typedef logic [7:0]  byteT;     // Data, address or register byte
    typedef logic [3:0]  slotT;     // Position within the CPU cycle, 0 while initialising
    typedef logic [15:0] initCntT;  // Free running init counter

    // One registered SDRAM command word
    typedef struct packed {
        logic        cke;
        logic        csN;
        logic        rasN;
        logic        casN;
        logic        weN;
        logic [1:0]  ba;
        logic [11:0] addr;
        logic        dqmL;
        logic        dqmH;
    } sdramCmdT;

    // Command flags, applied on the next bank register write
    typedef struct packed {
        logic setBankFf;
        logic maskSet;
        logic ledSet;
        logic ledGet;
    } cmdFlagsT;

    // Slot schedule after the PHI1 rise
    localparam slotT SlotIdle      = 4'd1;
    localparam slotT SlotVideoAct  = 4'd2;
    localparam slotT SlotVideoRead = 4'd3;
    localparam slotT SlotRefresh   = 4'd6;   // Also video data capture
    localparam slotT SlotRowLatch  = 4'd7;
    localparam slotT SlotCpuAct    = 4'd8;
    localparam slotT SlotCpuRw     = 4'd9;
    localparam slotT SlotDoeOn     = 4'd11;  // First slot driving the CPU bus
    localparam slotT SlotBank      = 4'd12;  // CPU capture, bank register write
    localparam slotT SlotNextRow1  = 4'd14;
    localparam slotT SlotNextRow2  = 4'd15;

    // Power-up init table
    localparam initCntT     InitPrechargeAt = 16'hFFC0;
    localparam logic [11:0] InitRefreshA    = 12'hFFD;  // Upper bits, even counts only
    localparam initCntT     InitModeAt      = 16'hFFE8;
    localparam logic [11:0] InitRefreshB    = 12'hFFF;  // Upper bits, even counts only
    localparam initCntT     InitCkeFrom     = 16'hFF00;

    // Single write, CL2, sequential, burst length 1
    localparam logic [11:0] ModeWord = 12'h220;

    // Magic sequence and command bytes
    localparam byteT MagicSeq [6] = '{8'hFF, 8'h00, 8'h55, 8'hAA, 8'hC1, 8'hAD};
    localparam byteT CmdForceFfA  = 8'hFF;
    localparam byteT CmdForceFfB  = 8'hF0;
    localparam byteT CmdMaskSet   = 8'hE0;
    localparam byteT CmdLedSet    = 8'hE2;
    localparam byteT CmdLedGet    = 8'hE3;
    localparam logic [2:0] CmdTimeoutMax = 3'd7;

    // Power-up RAMWorks state
    localparam byteT MaskReset = 8'h00;  // Banks 00 to 7F
    localparam logic LedReset  = 1'b0;

    // Clock off, deselected, everything masked
    localparam sdramCmdT SdramIdle = '{
        cke: 1'b0, csN: 1'b1, rasN: 1'b1, casN: 1'b1, weN: 1'b1,
        ba: 2'b00, addr: 12'h000, dqmL: 1'b1, dqmH: 1'b1
    };

endpackage

`default_nettype wire

// File: rtl/cycleTimer.sv
`timescale 1ns/1ps
`default_nettype none

module cycleTimer import ram2ePkg::*; (
    input  logic    C14M,
    input  logic    arstN,
    input  logic    phi1,
    output slotT    slot,
    output initCntT initCnt
);

    logic ready;  // Init table done
    logic phi1Q;  // PHI1 at the previous edge

    always_ff @(posedge C14M or negedge arstN) begin
        if (!arstN) begin
            initCnt <= '0;
            ready   <= 1'b0;
            phi1Q   <= 1'b0;
            slot    <= '0;
        end else begin
            initCnt <= initCnt + 16'd1;  // Keeps running, refresh pacing uses it
            phi1Q   <= phi1;
            if (initCnt == '1)
                ready <= 1'b1;
            // Restart on each PHI1 rise, otherwise count up and stick at 15
            if (ready && phi1 && !phi1Q)
                slot <= SlotIdle;
            else if (slot != '0 && slot != '1)
                slot <= slot + 4'd1;
        end
    end

    // Bus cycles only run once the init table is done
    assert property (@(posedge C14M) disable iff (!arstN)
        (slot != '0) |-> ready);

endmodule

`default_nettype wire

// File: ramworks/bankRegister.sv
`timescale 1ns/1ps
`default_nettype none

module bankRegister import ram2ePkg::*; (
    input  logic     C14M,
    input  logic     arstN,
    input  slotT     slot,
    input  byteT     rowAddr,   // Row latched at slot 7
    input  byteT     din,
    input  logic     nWe,
    input  logic     nC07x,
    input  cmdFlagsT cmdFlags,
    output logic     rwSel,
    output byteT     bank,
    output logic     ledOn
);

    byteT mask;     // Stored capacity mask
    logic forceFf;  // Bank goes to FF on this write

    // Forced by command, or LED get reporting the LED on
    assign forceFf = cmdFlags.setBankFf || (cmdFlags.ledGet && ledOn);

    always_ff @(posedge C14M or negedge arstN) begin
        if (!arstN) begin
            rwSel <= 1'b0;
            bank  <= '0;
            mask  <= MaskReset;
            ledOn <= LedReset;
        end else begin
            // Write to C071/C073 style locations decoded off the old row
            if (slot == SlotCpuRw)
                rwSel <= rowAddr[0] && !rowAddr[3] && !nWe && !nC07x;
            if (slot == SlotBank && rwSel) begin
                if (forceFf)
                    bank <= 8'hFF;
                else
                    bank <= din & {mask[7], ~mask[6:0]};  // Bit 7 passes, 6:0 inverted
                if (cmdFlags.maskSet)
                    mask <= {din[7], ~din[6:0]};
                if (cmdFlags.ledSet)
                    ledOn <= din[0];
            end
        end
    end

    // Without the top bit in the mask a normal write never reaches banks 80 and up
    assert property (@(posedge C14M) disable iff (!arstN)
        (bank != $past(bank) && !$past(mask[7]) && bank != 8'hFF) |-> !bank[7]);

endmodule

`default_nettype wire

// File: ramworks/cmdSequence.sv
`timescale 1ns/1ps
`default_nettype none

module cmdSequence import ram2ePkg::*; (
    input  logic     C14M,
    input  logic     arstN,
    input  slotT     slot,
    input  logic     rwSel,
    input  byteT     din,
    output cmdFlagsT cmdFlags
);

    logic [2:0] state;  // Bytes of the sequence seen so far
    logic [2:0] tout;   // CPU cycles without a bank register write
    logic       match;  // Current byte continues the sequence

    always_comb begin
        if (state >= 3'd6)
            match = 1'b1;  // Command byte and the write after it
        else
            match = (din == MagicSeq[state]);
    end

    always_ff @(posedge C14M or negedge arstN) begin
        if (!arstN) begin
            state    <= '0;
            tout     <= '0;
            cmdFlags <= '0;
        end else if (slot == SlotBank) begin
            if (rwSel) begin
                state <= match ? state + 3'd1 : 3'd0;  // 7 wraps to 0
                tout  <= '0;
                if (state == 3'd6) begin
                    // Decode the command byte
                    cmdFlags.setBankFf <= (din == CmdForceFfA) || (din == CmdForceFfB);
                    cmdFlags.maskSet   <= (din == CmdMaskSet);
                    cmdFlags.ledSet    <= (din == CmdLedSet);
                    cmdFlags.ledGet    <= (din == CmdLedGet);
                end else begin
                    cmdFlags <= '0;
                end
            end else begin
                tout <= tout + 3'd1;
                if (tout == CmdTimeoutMax)
                    state <= '0;  // Sequence abandoned
            end
        end
    end

endmodule

`default_nettype wire

// File: sdram/sdramSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sdramSequencer import ram2ePkg::*; (
    input  logic     C14M,
    input  logic     arstN,
    input  slotT     slot,
    input  initCntT  initCnt,
    input  byteT     ain,
    input  logic     nEn80,
    input  logic     nWe,
    input  logic     nWe80,
    input  byteT     bank,
    input  byteT     rdIn,
    output sdramCmdT sdramCmd,
    output byteT     rowAddr,
    output logic     rdOe,
    output logic     nDoe,
    output byteT     vout,
    output byteT     dout
);

    logic en80;   // Card selected for this CPU access
    logic doeEn;  // CPU data output window

    assign en80 = !nEn80;
    assign rdOe = en80 && !nWe80;          // CPU write, din onto the SDRAM bus
    assign nDoe = !(en80 && nWe && doeEn);  // CPU read, dout onto the IIe bus

    always_ff @(posedge C14M or negedge arstN) begin
        if (!arstN) begin
            sdramCmd <= SdramIdle;
            doeEn    <= 1'b0;
        end else begin
            doeEn <= (slot >= SlotDoeOn);  // Slot 0 counts as off
            if (slot == '0) begin
                // Init table, NOP unless a step matches
                sdramCmd      <= SdramIdle;
                sdramCmd.cke  <= (initCnt >= InitCkeFrom);
                sdramCmd.addr <= ModeWord;  // Only taken by the mode set
                if (initCnt == InitPrechargeAt) begin
                    sdramCmd.csN      <= 1'b0;  // Precharge all
                    sdramCmd.rasN     <= 1'b0;
                    sdramCmd.weN      <= 1'b0;
                    sdramCmd.addr[10] <= 1'b1;
                end else if ((initCnt[15:4] == InitRefreshA || initCnt[15:4] == InitRefreshB)
                             && !initCnt[0]) begin
                    sdramCmd.csN  <= 1'b0;  // Auto-refresh, 8x per group
                    sdramCmd.rasN <= 1'b0;
                    sdramCmd.casN <= 1'b0;
                end else if (initCnt == InitModeAt) begin
                    sdramCmd.csN  <= 1'b0;  // Mode register set
                    sdramCmd.rasN <= 1'b0;
                    sdramCmd.casN <= 1'b0;
                    sdramCmd.weN  <= 1'b0;
                end
            end else begin
                // NOP defaults, low address byte holds its last latch
                sdramCmd.csN        <= 1'b1;
                sdramCmd.rasN       <= 1'b1;
                sdramCmd.casN       <= 1'b1;
                sdramCmd.weN        <= 1'b1;
                sdramCmd.ba         <= 2'b00;
                sdramCmd.addr[11:8] <= 4'h0;
                sdramCmd.dqmL       <= 1'b1;
                sdramCmd.dqmH       <= 1'b1;
                // Clock on for video, per card select for CPU, off while idle
                if (slot < SlotCpuAct)
                    sdramCmd.cke <= 1'b1;
                else if (slot < SlotDoeOn)
                    sdramCmd.cke <= en80;
                else
                    sdramCmd.cke <= 1'b0;
                case (slot)
                    SlotVideoAct: begin
                        sdramCmd.csN  <= 1'b0;  // Activate bank 0, row from slot 14/15
                        sdramCmd.rasN <= 1'b0;
                    end
                    SlotVideoRead: begin
                        sdramCmd.csN  <= 1'b0;  // Read with auto-precharge
                        sdramCmd.casN <= 1'b0;
                        sdramCmd.addr <= {4'b0100, ain};
                        sdramCmd.dqmL <= 1'b0;  // Video always low byte
                    end
                    SlotRefresh: begin
                        if (initCnt[5:4] == 2'b00) begin
                            sdramCmd.csN  <= 1'b0;  // One refresh every fourth cycle
                            sdramCmd.rasN <= 1'b0;
                            sdramCmd.casN <= 1'b0;
                        end
                    end
                    SlotRowLatch:
                        sdramCmd.addr[7:0] <= ain;  // CPU row
                    SlotCpuAct: begin
                        sdramCmd.csN        <= nEn80;
                        sdramCmd.rasN       <= 1'b0;
                        sdramCmd.ba         <= bank[5:4];
                        sdramCmd.addr[11:8] <= bank[3:0];
                    end
                    SlotCpuRw: begin
                        sdramCmd.csN  <= nEn80;
                        sdramCmd.casN <= 1'b0;
                        sdramCmd.weN  <= nWe80;
                        sdramCmd.ba   <= bank[5:4];
                        sdramCmd.addr <= {2'b01, 1'b0, bank[7], ain};  // Auto-precharge
                        sdramCmd.dqmL <= bank[6];   // Bit 6 picks the high byte
                        sdramCmd.dqmH <= !bank[6];
                    end
                    SlotNextRow1, SlotNextRow2:
                        sdramCmd.addr[7:0] <= ain;  // Row for next video read
                    default: ;
                endcase
            end
        end
    end

    // Row copy for the bank register decode
    always_ff @(posedge C14M) begin
        if (slot == SlotRowLatch)
            rowAddr <= ain;
    end

    // Read data settles mid slot, sample on the falling edge
    always_ff @(negedge C14M) begin
        if (slot == SlotRefresh)
            vout <= rdIn;
        if (slot == SlotBank)
            dout <= rdIn;
    end

    // No command may be selected into a stopped SDRAM clock
    assert property (@(posedge C14M) disable iff (!arstN)
        (slot != '0 && !sdramCmd.csN) |-> sdramCmd.cke);

endmodule

`default_nettype wire

// File: rtl/ram2eTop.sv
`timescale 1ns/1ps
`default_nettype none

module ram2eTop import ram2ePkg::*; (
    input  logic     C14M,
    input  logic     arstN,
    input  logic     phi1,
    input  logic     nWe,
    input  logic     nWe80,
    input  logic     nEn80,
    input  logic     nC07x,
    input  byteT     ain,      // Multiplexed DRAM address from the IIe
    input  byteT     din,      // CPU data bus, also driven onto the SDRAM when rdOe
    input  byteT     rdIn,     // SDRAM data toward the card
    output logic     led,
    output logic     nDoe,
    output logic     rdOe,
    output sdramCmdT sdramCmd,
    output byteT     vout,
    output byteT     dout
);

    slotT     slot;
    initCntT  initCnt;
    byteT     rowAddr;
    byteT     bank;
    logic     rwSel;
    logic     ledOn;
    cmdFlagsT cmdFlags;

    // Activity LED, lit only while the card is enabled
    assign led = !(!nEn80 && ledOn);

    cycleTimer cycleTimer_i (
        .C14M    (C14M),
        .arstN   (arstN),
        .phi1    (phi1),
        .slot    (slot),
        .initCnt (initCnt)
    );

    bankRegister bankRegister_i (
        .C14M     (C14M),
        .arstN    (arstN),
        .slot     (slot),
        .rowAddr  (rowAddr),
        .din      (din),
        .nWe      (nWe),
        .nC07x    (nC07x),
        .cmdFlags (cmdFlags),
        .rwSel    (rwSel),
        .bank     (bank),
        .ledOn    (ledOn)
    );

    cmdSequence cmdSequence_i (
        .C14M     (C14M),
        .arstN    (arstN),
        .slot     (slot),
        .rwSel    (rwSel),
        .din      (din),
        .cmdFlags (cmdFlags)
    );

    sdramSequencer sdramSequencer_i (
        .C14M     (C14M),
        .arstN    (arstN),
        .slot     (slot),
        .initCnt  (initCnt),
        .ain      (ain),
        .nEn80    (nEn80),
        .nWe      (nWe),
        .nWe80    (nWe80),
        .bank     (bank),
        .rdIn     (rdIn),
        .sdramCmd (sdramCmd),
        .rowAddr  (rowAddr),
        .rdOe     (rdOe),
        .nDoe     (nDoe),
        .vout     (vout),
        .dout     (dout)
    );

endmodule

`default_nettype wire

// File: bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic C14M,
    output logic arstN
);

    initial begin
        C14M = 1'b0;
        forever #10 C14M = ~C14M;  // 20 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge C14M);
        #2 arstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/sdramModel.sv
`timescale 1ns/1ps
`default_nettype none

module sdramModel import ram2ePkg::*; (
    input  logic     C14M,
    input  sdramCmdT cmd,
    input  logic     rdOe,   // Card drives dq onto the SDRAM bus
    input  byteT     dq,
    output byteT     rdIn
);

    logic [11:0] rowOf [4];            // Open row per bank
    byteT        mem [logic [23:0]];   // Key is ba, row, addr8, column, byte select

    initial begin
        for (int b = 0; b < 4; b++)
            rowOf[b] <= '0;
        rdIn <= '0;
    end

    always @(posedge C14M) begin : decode
        logic [23:0] key;
        key = {cmd.ba, rowOf[cmd.ba], cmd.addr[8:0], cmd.dqmL};  // dqmL high means upper byte
        if (!cmd.csN) begin
            if (!cmd.rasN && cmd.casN && cmd.weN)
                rowOf[cmd.ba] <= cmd.addr;  // Activate
            else if (cmd.rasN && !cmd.casN) begin
                if (!cmd.weN) begin
                    if (rdOe)
                        mem[key] = dq;
                end else if (mem.exists(key))
                    rdIn <= mem[key];
                else
                    rdIn <= rowOf[cmd.ba][7:0] ^ cmd.addr[7:0] ^ {6'b0, cmd.ba};  // Fresh cell
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/ram2eTb.sv
`timescale 1ns/1ps
`default_nettype none

module ram2eTb import ram2ePkg::*; ();

    localparam int OpRead   = 0;
    localparam int OpWrite  = 1;
    localparam int OpBankW  = 2;
    localparam int OpLedChk = 3;

    logic     C14M, arstN, phi1, nWe, nWe80, nEn80, nC07x;
    byteT     ain, din, rdIn, vout, dout;
    logic     led, nDoe, rdOe;
    sdramCmdT sdramCmd;

    int   opQ[$];
    int   lineQ[$];
    byteT rowQ[$], colQ[$], dataQ[$], expQ[$];
    byteT expBank = '0;     // Bank the card should be using now
    logic busStarted = 1'b0;
    int   modeCnt = 0;
    int   refCnt = 0;
    logic [11:0] modeAddr = '0;
    int   cycles = 0;
    int   limit = 32'h7fff_ffff;

    clockGen clockGen_i (.C14M(C14M), .arstN(arstN));

    sdramModel sdramModel_i (.C14M(C14M), .cmd(sdramCmd), .rdOe(rdOe), .dq(din), .rdIn(rdIn));

    ram2eTop ram2eTop_i (
        .C14M(C14M), .arstN(arstN), .phi1(phi1), .nWe(nWe), .nWe80(nWe80),
        .nEn80(nEn80), .nC07x(nC07x), .ain(ain), .din(din), .rdIn(rdIn),
        .led(led), .nDoe(nDoe), .rdOe(rdOe), .sdramCmd(sdramCmd), .vout(vout), .dout(dout)
    );

    function automatic string opName(int op);
        case (op)
            OpRead:  return "READ";
            OpWrite: return "WRITE";
            OpBankW: return "BANKW";
            default: return "LEDCHK";
        endcase
    endfunction

    function automatic int opCode(logic [47:0] w);
        if (w == "READ")   return OpRead;
        if (w == "WRITE")  return OpWrite;
        if (w == "BANKW")  return OpBankW;
        if (w == "LEDCHK") return OpLedChk;
        return -1;
    endfunction

    // Video addresses walk with the cycle index
    function automatic byteT vrowOf(int i);
        return byteT'(i * 11 + 9);
    endfunction

    function automatic byteT vcolOf(int i);
        return byteT'(i * 37 + 5);
    endfunction

    task automatic checkVal(string what, int expV, int actV);
        assert (expV == actV) else begin
            $display("mismatch %s expected %h actual %h", what, expV, actV);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic stopOn(string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Init commands only, counted until bus cycles begin
    always @(posedge C14M) begin
        if (arstN && !busStarted && !sdramCmd.csN && !sdramCmd.rasN && !sdramCmd.casN) begin
            if (!sdramCmd.weN) begin
                modeCnt++;
                modeAddr = sdramCmd.addr;
            end else
                refCnt++;
        end
    end

    always @(posedge C14M) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d clock cycles", limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // One CPU cycle, PHI1 high for slots 1 to 7
    task automatic runCycle(int i);
        int    op;
        string tname;
        op    = opQ[i];
        tname = $sformatf("%s line %0d", opName(op), lineQ[i]);
        nEn80 = !(op == OpRead || op == OpWrite || op == OpLedChk);
        nWe   = !(op == OpWrite || op == OpBankW);
        nWe80 = (op != OpWrite);
        nC07x = (op != OpBankW);
        for (int k = 1; k <= 14; k++) begin
            @(posedge C14M);
            #2;
            if (nWe80)
                checkVal({tname, " rdOe"}, 0, rdOe);
            if (k == 7 && i > 0)
                checkVal({tname, " vout"}, vrowOf(i) ^ vcolOf(i), vout);
            if (k == 9 && !nEn80) begin  // CPU activate
                checkVal({tname, " act rasN"}, 0, sdramCmd.rasN);
                checkVal({tname, " act ba"}, expBank[5:4], sdramCmd.ba);
                checkVal({tname, " act addr"}, expBank[3:0], sdramCmd.addr[11:8]);
            end
            if (k == 10 && !nEn80) begin  // CPU read or write
                checkVal({tname, " rw casN"}, 0, sdramCmd.casN);
                checkVal({tname, " rw weN"}, nWe80, sdramCmd.weN);
                checkVal({tname, " rw addr8"}, expBank[7], sdramCmd.addr[8]);
                checkVal({tname, " rw dqmL"}, expBank[6], sdramCmd.dqmL);
                checkVal({tname, " rw dqmH"}, !expBank[6], sdramCmd.dqmH);
            end
            if (k == 9 && op == OpLedChk)
                checkVal({tname, " led"}, expQ[i][0], led);
            if (k == 13 && op == OpRead) begin
                checkVal({tname, " dout"}, expQ[i], dout);
                checkVal({tname, " nDoe"}, 0, nDoe);
            end
            phi1 = (k < 7 || k == 14);
            din  = (k <= 6) ? byteT'($urandom()) : dataQ[i];
            if (k == 3)
                ain = vcolOf(i);
            if (k == 7)
                ain = rowQ[i];
            if (k == 9)
                ain = colQ[i];
            if (k == 14)
                ain = vrowOf(i + 1);  // Row for the next video read
        end
        if (op == OpBankW)
            expBank = expQ[i];
    endtask

    initial begin : main
        int          fd;
        int          n;
        int          lineNo;
        string       line;
        logic [47:0] opWord;
        byteT        r, c, d, e;
        void'($urandom(32'ha5b5_1c56));
        phi1  = 1'b0;
        nWe   = 1'b1;
        nWe80 = 1'b1;
        nEn80 = 1'b1;
        nC07x = 1'b1;
        ain   = '0;
        din   = '0;
        fd = $fopen("bench/stimulus.txt", "r");
        if (fd == 0)
            stopOn("cannot open bench/stimulus.txt");
        lineNo = 0;
        while ($fgets(line, fd) != 0) begin
            lineNo++;
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%s %h %h %h %h", opWord, r, c, d, e);
            if (n != 5 || opCode(opWord) < 0)
                stopOn($sformatf("stimulus line %0d cannot be parsed", lineNo));
            opQ.push_back(opCode(opWord));
            lineQ.push_back(lineNo);
            rowQ.push_back(r);
            colQ.push_back(c);
            dataQ.push_back(d);
            expQ.push_back(e);
        end
        $fclose(fd);
        limit = 65536 + 14 * 4 * opQ.size() + 1000;

        @(posedge C14M);
        #2;
        checkVal("reset cke", 0, sdramCmd.cke);
        checkVal("reset csN", 1, sdramCmd.csN);
        checkVal("reset led", 1, led);
        checkVal("reset nDoe", 1, nDoe);

        @(posedge arstN);
        repeat (65536 + 8) @(posedge C14M);
        #2;
        busStarted = 1'b1;
        checkVal("init mode count", 1, modeCnt);
        checkVal("init mode word", ModeWord, modeAddr);
        checkVal("init refresh count", 16, refCnt);

        phi1 = 1'b1;  // First rise, seen on the next edge
        for (int i = 0; i < opQ.size(); i++)
            runCycle(i);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/stimulus.txt
# op row col data expected, all hex
# READ/LEDCHK ignore data, WRITE ignores expected, BANKW expected is the new bank
READ 12 34 00 26
READ A5 0F 00 AA
BANKW 73 00 9E 1E
WRITE 21 43 5C 00
READ 21 43 00 5C
BANKW 73 00 E5 65
WRITE 21 43 A7 00
READ 21 43 00 A7
BANKW 73 00 FF 7F
BANKW 73 00 00 00
BANKW 73 00 55 55
READ 10 20 00 31
READ 10 20 00 31
READ 10 20 00 31
READ 10 20 00 31
READ 10 20 00 31
READ 10 20 00 31
READ 10 20 00 31
READ 10 20 00 31
BANKW 73 00 AA 2A
BANKW 73 00 C1 41
BANKW 73 00 AD 2D
BANKW 73 00 E0 60
BANKW 73 00 3F 3F
BANKW 73 00 C3 43
BANKW 73 00 FF 7F
BANKW 73 00 00 00
BANKW 73 00 55 55
BANKW 73 00 AA 2A
BANKW 73 00 C1 41
BANKW 73 00 AD 2D
BANKW 73 00 E0 60
BANKW 73 00 C0 40
BANKW 73 00 F5 C0
WRITE 33 44 6D 00
READ 33 44 00 6D
BANKW 73 00 FF C0
BANKW 73 00 00 00
BANKW 73 00 55 40
BANKW 73 00 AA 80
BANKW 73 00 C1 C0
BANKW 73 00 AD 80
BANKW 73 00 E2 C0
BANKW 73 00 01 00
LEDCHK 05 06 00 00
BANKW 73 00 FF C0
BANKW 73 00 00 00
BANKW 73 00 55 40
BANKW 73 00 AA 80
BANKW 73 00 C1 C0
BANKW 73 00 AD 80
BANKW 73 00 E3 C0
BANKW 73 00 12 FF
READ 05 06 00 00

// File: src.f
common/ram2ePkg.sv
rtl/cycleTimer.sv
ramworks/bankRegister.sv
ramworks/cmdSequence.sv
sdram/sdramSequencer.sv
rtl/ram2eTop.sv
bench/clockGen.sv
bench/sdramModel.sv
bench/ram2eTb.sv

// File: run.sh
#!/bin/sh
# Build and run, exit status follows the simulation
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module ram2eTb -o ram2eSim \
    && ./obj_dir/ram2eSim \
    || exit 1
